// ==== design/autotest_frame_pkg.sv ====
`default_nettype none

package autotest_frame_pkg;

  // card block layout
  localparam int BLOCK_BYTES = 512;
  localparam int HDR_BYTES = 20;

  // operand and result width, the header layout below depends on it
  localparam int WORD_W = 32;

  // marks a block that holds a valid test vector
  localparam logic [WORD_W-1:0] SIGNATURE = 32'hAABB_CCDD;

  typedef logic [7:0] sd_byte_t;

  // raw view is indexed by position in the block, byte 0 in the low bits
  // operands and expected value come out little-endian from this layout;
  // the signature keeps its bytes in card order and is read big-endian
  typedef union packed {
    sd_byte_t [HDR_BYTES-1:0] raw;
    struct packed {
      logic [WORD_W-1:0] expected;
      logic [WORD_W-1:0] operand_3;
      logic [WORD_W-1:0] operand_2;
      logic [WORD_W-1:0] operand_1;
      sd_byte_t [3:0]    signature;
    } field;
  } test_header_u;

endpackage

`default_nettype wire

// ==== design/autotest_ctrl_pkg.sv ====
`default_nettype none

package autotest_ctrl_pkg;

  // sequencer states
  typedef enum logic [3:0] {
    IDLE,
    SPI_RESET,
    SPI_WAIT,
    READ_BLOCK,
    CHECK_SIG,
    RUN,
    CHECK,
    NEXT_BLOCK,
    HALT
  } seq_state_t;

  // counter widths
  localparam int BLK_ADDR_W = 32;
  localparam int CYCLE_W = 32;
  localparam int ERR_W = 32;

endpackage

`default_nettype wire

// ==== design/block_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module block_reader
  import autotest_frame_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         read_go_i,
  input  logic         spi_busy_i,
  input  sd_byte_t     spi_data_i,
  output logic         spi_r_block_o,
  output logic         spi_r_byte_o,
  output logic         read_done_o,
  output test_header_u header_o
);

  localparam int CNT_W = $clog2(BLOCK_BYTES);
  localparam int IDX_W = $clog2(HDR_BYTES);
  localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(BLOCK_BYTES - 1);
  localparam logic [CNT_W-1:0] HDR_END = CNT_W'(HDR_BYTES);

  localparam logic [2:0] R_IDLE = 3'd0;
  localparam logic [2:0] R_BLOCK = 3'd1;
  localparam logic [2:0] R_BLOCK_WAIT = 3'd2;
  localparam logic [2:0] R_BYTE = 3'd3;
  localparam logic [2:0] R_BYTE_WAIT = 3'd4;
  localparam logic [2:0] R_DONE = 3'd5;

  logic [2:0] state;
  logic [CNT_W-1:0] byte_cnt;
  logic byte_valid;
  test_header_u header;

  // data is on the bus when busy falls after a byte request
  assign byte_valid = (state == R_BYTE_WAIT) && !spi_busy_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= R_IDLE;
      byte_cnt <= '0;
      read_done_o <= 1'b0;
    end else begin
      read_done_o <= 1'b0;
      case (state)
        R_IDLE: begin
          if (read_go_i) begin
            byte_cnt <= '0;
            state <= R_BLOCK;
          end
        end
        R_BLOCK: if (spi_busy_i) state <= R_BLOCK_WAIT;
        R_BLOCK_WAIT: if (!spi_busy_i) state <= R_BYTE;
        R_BYTE: if (spi_busy_i) state <= R_BYTE_WAIT;
        R_BYTE_WAIT: begin
          if (byte_valid) begin
            if (byte_cnt == LAST_BYTE) begin
              read_done_o <= 1'b1;
              state <= R_DONE;
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
              state <= R_BYTE;
            end
          end
        end
        // wait for the request to drop so the next one is a fresh edge
        R_DONE: if (!read_go_i) state <= R_IDLE;
        default: state <= R_IDLE;
      endcase
    end
  end

  // header bytes land at their block position, the rest is dropped
  always_ff @(posedge clk) begin
    if (state == R_IDLE && read_go_i) begin
      header <= '0;
    end else if (byte_valid && byte_cnt < HDR_END) begin
      header.raw[byte_cnt[IDX_W-1:0]] <= spi_data_i;
    end
  end

  assign spi_r_block_o = (state == R_BLOCK) || (state == R_BLOCK_WAIT) ||
                         (state == R_BYTE) || (state == R_BYTE_WAIT);
  assign spi_r_byte_o = (state == R_BYTE);
  assign header_o = header;

endmodule

`default_nettype wire

// ==== design/uut_runner.sv ====
`timescale 1ns/1ps
`default_nettype none

module uut_runner
  import autotest_ctrl_pkg::*;
#(
  parameter logic [CYCLE_W-1:0] TIMEOUT_CYCLES = 32'h1000_0000
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               run_go_i,
  input  logic               end_uut_i,
  output logic               uut_rst_o,
  output logic               run_done_o,
  output logic [CYCLE_W-1:0] exec_cycles_o
);

  logic [CYCLE_W-1:0] cycles;

  always_ff @(posedge clk) begin
    if (rst) begin
      uut_rst_o <= 1'b1;
      run_done_o <= 1'b0;
      cycles <= '0;
    end else begin
      run_done_o <= 1'b0;
      if (run_go_i) begin
        uut_rst_o <= 1'b0;
        cycles <= '0;
      end else if (!uut_rst_o) begin
        // stop on the end flag or once the count sits at the cap
        if (end_uut_i || cycles == TIMEOUT_CYCLES) begin
          uut_rst_o <= 1'b1;
          run_done_o <= 1'b1;
        end else begin
          cycles <= cycles + 1'b1;
        end
      end
    end
  end

  assign exec_cycles_o = cycles;

endmodule

`default_nettype wire

// ==== design/result_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_checker
  import autotest_frame_pkg::*, autotest_ctrl_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              run_done_i,
  input  logic [WORD_W-1:0] expected_i,
  input  logic [WORD_W-1:0] uut_result_i,
  output logic              test_done_o,
  output logic [ERR_W-1:0]  err_count_o
);

  logic [WORD_W-1:0] result_q;
  logic [ERR_W-1:0] err_q;
  logic mismatch;

  // uut output is sampled as the run ends
  always_ff @(posedge clk) begin
    if (run_done_i) begin
      result_q <= uut_result_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      test_done_o <= 1'b0;
      err_q <= '0;
    end else begin
      test_done_o <= run_done_i;
      err_q <= err_count_o;
    end
  end

  // compare in the cycle after capture, count shows with test_done
  assign mismatch = test_done_o && (result_q != expected_i);
  assign err_count_o = err_q + ERR_W'(mismatch);

endmodule

`default_nettype wire

// ==== design/test_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module test_sequencer
  import autotest_frame_pkg::*, autotest_ctrl_pkg::*;
#(
  parameter logic [BLK_ADDR_W-1:0] START_BLOCK = 32'h0010_0000
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start_i,
  input  logic                  spi_busy_i,
  output logic                  spi_rst_o,
  output logic                  read_go_o,
  input  logic                  read_done_i,
  input  logic [WORD_W-1:0]     header_sig_i,
  output logic                  run_go_o,
  input  logic                  test_done_i,
  output logic [BLK_ADDR_W-1:0] spi_block_addr_o,
  output logic                  halt_o
);

  seq_state_t state;
  logic [BLK_ADDR_W-1:0] blk_addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      blk_addr <= START_BLOCK;
      run_go_o <= 1'b0;
      halt_o <= 1'b0;
    end else begin
      run_go_o <= 1'b0;
      case (state)
        IDLE: begin
          if (start_i) begin
            blk_addr <= START_BLOCK;
            halt_o <= 1'b0;
            state <= SPI_RESET;
          end
        end
        // hold the reset strobe until the host takes it
        SPI_RESET: if (spi_busy_i) state <= SPI_WAIT;
        SPI_WAIT: if (!spi_busy_i) state <= READ_BLOCK;
        READ_BLOCK: if (read_done_i) state <= CHECK_SIG;
        CHECK_SIG: begin
          if (header_sig_i == SIGNATURE) begin
            run_go_o <= 1'b1;
            state <= RUN;
          end else begin
            state <= HALT;
          end
        end
        // run_go is high during this cycle
        RUN: state <= CHECK;
        CHECK: if (test_done_i) state <= NEXT_BLOCK;
        NEXT_BLOCK: begin
          blk_addr <= blk_addr + 1'b1;
          state <= READ_BLOCK;
        end
        // halt level stays up until the next start
        HALT: begin
          halt_o <= 1'b1;
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign spi_rst_o = (state == SPI_RESET);
  assign read_go_o = (state == READ_BLOCK);
  assign spi_block_addr_o = blk_addr;

endmodule

`default_nettype wire

// ==== design/autotest_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module autotest_top
  import autotest_frame_pkg::*, autotest_ctrl_pkg::*;
#(
  parameter logic [BLK_ADDR_W-1:0] START_BLOCK = 32'h0010_0000,
  parameter logic [CYCLE_W-1:0]    TIMEOUT_CYCLES = 32'h1000_0000
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start_i,
  input  logic                  spi_busy_i,
  input  sd_byte_t              spi_data_i,
  output logic                  spi_rst_o,
  output logic                  spi_r_block_o,
  output logic                  spi_r_byte_o,
  output logic [BLK_ADDR_W-1:0] spi_block_addr_o,
  output logic                  uut_rst_o,
  input  logic                  end_uut_i,
  output logic [WORD_W-1:0]     uut_in_1_o,
  output logic [WORD_W-1:0]     uut_in_2_o,
  output logic [WORD_W-1:0]     uut_in_3_o,
  input  logic [WORD_W-1:0]     uut_result_i,
  output logic                  test_done_o,
  output logic                  halt_o,
  output logic [CYCLE_W-1:0]    exec_cycles_o,
  output logic [ERR_W-1:0]      err_count_o
);

  logic read_go;
  logic read_done;
  logic run_go;
  logic run_done;
  logic [WORD_W-1:0] header_sig;
  test_header_u header;

  // signature bytes in card order, first byte most significant
  assign header_sig = {header.field.signature[0], header.field.signature[1],
                       header.field.signature[2], header.field.signature[3]};

  assign uut_in_1_o = header.field.operand_1;
  assign uut_in_2_o = header.field.operand_2;
  assign uut_in_3_o = header.field.operand_3;

  test_sequencer #(
    .START_BLOCK(START_BLOCK)
  ) u_sequencer (
    .clk(clk),
    .rst(rst),
    .start_i(start_i),
    .spi_busy_i(spi_busy_i),
    .spi_rst_o(spi_rst_o),
    .read_go_o(read_go),
    .read_done_i(read_done),
    .header_sig_i(header_sig),
    .run_go_o(run_go),
    .test_done_i(test_done_o),
    .spi_block_addr_o(spi_block_addr_o),
    .halt_o(halt_o)
  );

  block_reader u_reader (
    .clk(clk),
    .rst(rst),
    .read_go_i(read_go),
    .spi_busy_i(spi_busy_i),
    .spi_data_i(spi_data_i),
    .spi_r_block_o(spi_r_block_o),
    .spi_r_byte_o(spi_r_byte_o),
    .read_done_o(read_done),
    .header_o(header)
  );

  uut_runner #(
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
  ) u_runner (
    .clk(clk),
    .rst(rst),
    .run_go_i(run_go),
    .end_uut_i(end_uut_i),
    .uut_rst_o(uut_rst_o),
    .run_done_o(run_done),
    .exec_cycles_o(exec_cycles_o)
  );

  result_checker u_checker (
    .clk(clk),
    .rst(rst),
    .run_done_i(run_done),
    .expected_i(header.field.expected),
    .uut_result_i(uut_result_i),
    .test_done_o(test_done_o),
    .err_count_o(err_count_o)
  );

endmodule

`default_nettype wire

// ==== testbench/autotest_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module autotest_asserts (
  input logic clk,
  input logic rst,
  input logic spi_rst_i,
  input logic spi_r_block_i,
  input logic uut_rst_i,
  input logic run_done_i
);

  int fail_count = 0;

  // host serves one kind of request at a time
  rst_vs_block: assert property (@(posedge clk) disable iff (rst)
    !(spi_rst_i && spi_r_block_i))
    else begin
      $error("spi reset strobe high during a block read");
      fail_count++;
    end

  // uut stays parked while the card is read
  uut_parked: assert property (@(posedge clk) disable iff (rst)
    spi_r_block_i |-> uut_rst_i)
    else begin
      $error("uut out of reset during a block read");
      fail_count++;
    end

  run_done_pulse: assert property (@(posedge clk) disable iff (rst)
    run_done_i |=> !run_done_i)
    else begin
      $error("run_done held longer than one cycle");
      fail_count++;
    end

endmodule

bind autotest_top autotest_asserts u_asserts (
  .clk(clk),
  .rst(rst),
  .spi_rst_i(spi_rst_o),
  .spi_r_block_i(spi_r_block_o),
  .uut_rst_i(uut_rst_o),
  .run_done_i(run_done)
);

`default_nettype wire

// ==== testbench/autotest_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module autotest_tb
  import autotest_frame_pkg::*, autotest_ctrl_pkg::*;
();

  localparam logic [BLK_ADDR_W-1:0] START_BLOCK = 32'h0010_0000;
  localparam logic [CYCLE_W-1:0] TIMEOUT = 32'd64;
  localparam int NUM_BLOCKS = 10;
  localparam int COLS = 7;
  localparam int CYCLE_LIMIT = NUM_BLOCKS * BLOCK_BYTES * 8 + NUM_BLOCKS * 200;
  localparam int QUIET_CYCLES = 100;
  localparam logic [31:0] SEED = 32'hdf13_2c44;

  logic clk = 1'b0;
  logic rst;
  logic start_i;
  logic spi_busy_i;
  sd_byte_t spi_data_i;
  logic spi_rst_o;
  logic spi_r_block_o;
  logic spi_r_byte_o;
  logic [BLK_ADDR_W-1:0] spi_block_addr_o;
  logic uut_rst_o;
  logic end_uut_i;
  logic [WORD_W-1:0] uut_in_1_o;
  logic [WORD_W-1:0] uut_in_2_o;
  logic [WORD_W-1:0] uut_in_3_o;
  logic [WORD_W-1:0] uut_result_i;
  logic test_done_o;
  logic halt_o;
  logic [CYCLE_W-1:0] exec_cycles_o;
  logic [ERR_W-1:0] err_count_o;

  // seven words per block in golden file column order
  logic [31:0] golden [NUM_BLOCKS*COLS];
  logic [31:0] mismatch_sum = '0;
  logic [31:0] uut_cnt;
  int tests_seen = 0;
  int good_tests = 0;
  int value_errors = 0;
  int other_errors = 0;

  autotest_top #(
    .START_BLOCK(START_BLOCK),
    .TIMEOUT_CYCLES(TIMEOUT)
  ) uut (
    .clk(clk),
    .rst(rst),
    .start_i(start_i),
    .spi_busy_i(spi_busy_i),
    .spi_data_i(spi_data_i),
    .spi_rst_o(spi_rst_o),
    .spi_r_block_o(spi_r_block_o),
    .spi_r_byte_o(spi_r_byte_o),
    .spi_block_addr_o(spi_block_addr_o),
    .uut_rst_o(uut_rst_o),
    .end_uut_i(end_uut_i),
    .uut_in_1_o(uut_in_1_o),
    .uut_in_2_o(uut_in_2_o),
    .uut_in_3_o(uut_in_3_o),
    .uut_result_i(uut_result_i),
    .test_done_o(test_done_o),
    .halt_o(halt_o),
    .exec_cycles_o(exec_cycles_o),
    .err_count_o(err_count_o)
  );

  always #4 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERROR t=%0t %s: got %h, expected %h", $time, name, actual, expected);
      value_errors++;
    end
  endtask

  task automatic finish_run();
    int assert_errors;
    assert_errors = uut.u_asserts.fail_count;
    $display("value errors: %0d, other failures: %0d, assertion failures: %0d",
             value_errors, other_errors, assert_errors);
    if (value_errors == 0 && other_errors == 0 && assert_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  // signature bytes go out big-endian and the other header words little-endian
  function automatic sd_byte_t card_byte(input int blk, input int idx);
    logic [31:0] word;
    int field;
    if (idx >= HDR_BYTES) return 8'(idx);
    if (blk >= NUM_BLOCKS) return 8'h00;
    field = idx / 4;
    word = golden[blk * COLS + field];
    if (field == 0) return 8'(word >> (8 * (3 - idx % 4)));
    return 8'(word >> (8 * (idx % 4)));
  endfunction

  function automatic logic [31:0] latency_of(input int blk);
    if (blk >= NUM_BLOCKS) return '0;
    return golden[blk * COLS + 5];
  endfunction

  // busy rises after 1 to 3 cycles and data appears as it falls
  task automatic serve_request(input sd_byte_t data);
    int delay;
    delay = 1 + ($urandom % 3);
    repeat (delay) @(posedge clk);
    spi_busy_i <= 1'b1;
    @(posedge clk);
    spi_busy_i <= 1'b0;
    spi_data_i <= data;
  endtask

  initial begin : sd_host
    int byte_idx;
    int host_blk;
    bit block_open;
    void'($urandom(SEED));
    block_open = 0;
    byte_idx = 0;
    host_blk = 0;
    forever begin
      @(posedge clk);
      if (rst) begin
        block_open = 0;
      end else if (spi_rst_o) begin
        serve_request(8'h00);
      end else if (spi_r_byte_o) begin
        serve_request(card_byte(host_blk, byte_idx));
        byte_idx++;
      end else if (spi_r_block_o && !block_open) begin
        block_open = 1;
        byte_idx = 0;
        host_blk = tests_seen;
        check_value("spi_block_addr_o", spi_block_addr_o, START_BLOCK + 32'(tests_seen));
        serve_request(8'h00);
      end else if (!spi_r_block_o) begin
        block_open = 0;
      end
    end
  end

  // uut model ends after the block latency unless that is 0
  always @(posedge clk) begin
    if (rst || uut_rst_o) begin
      uut_cnt <= '0;
      end_uut_i <= 1'b0;
      uut_result_i <= '0;
    end else begin
      uut_cnt <= uut_cnt + 1;
      uut_result_i <= (uut_in_1_o + uut_in_2_o) ^ uut_in_3_o;
      if (latency_of(tests_seen) != 0 && uut_cnt + 1 == latency_of(tests_seen)) begin
        end_uut_i <= 1'b1;
      end
    end
  end

  always @(posedge clk) begin : result_monitor
    int base;
    if (!rst && test_done_o) begin
      if (tests_seen >= good_tests) begin
        $display("test_done_o pulsed for block %0d, which has a bad signature", tests_seen);
        other_errors++;
      end else begin
        base = tests_seen * COLS;
        check_value("uut_in_1_o", uut_in_1_o, golden[base + 1]);
        check_value("uut_in_2_o", uut_in_2_o, golden[base + 2]);
        check_value("uut_in_3_o", uut_in_3_o, golden[base + 3]);
        check_value("err_count_o", err_count_o, mismatch_sum + golden[base + 6]);
        check_value("exec_cycles_o", exec_cycles_o,
                    (golden[base + 5] == 0) ? TIMEOUT : golden[base + 5]);
        mismatch_sum <= mismatch_sum + golden[base + 6];
      end
      tests_seen <= tests_seen + 1;
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not halt within %0d cycles", CYCLE_LIMIT);
    other_errors++;
    finish_run();
  end

  initial begin : main
    rst = 1'b1;
    start_i = 1'b0;
    spi_busy_i = 1'b0;
    spi_data_i = '0;
    end_uut_i = 1'b0;
    uut_result_i = '0;
    $readmemh("testbench/autotest_golden.txt", golden);
    // tests stop at the first block without a valid signature
    while (good_tests < NUM_BLOCKS && golden[good_tests * COLS] == SIGNATURE) begin
      good_tests++;
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    start_i <= 1'b1;
    @(posedge clk);
    start_i <= 1'b0;
    while (!halt_o) @(posedge clk);
    repeat (QUIET_CYCLES) begin
      @(posedge clk);
      check_value("halt_o", halt_o, 1'b1);
      check_value("uut_rst_o", uut_rst_o, 1'b1);
    end
    check_value("tests completed", tests_seen, good_tests);
    finish_run();
  end

endmodule

`default_nettype wire

// ==== compile.f ====
design/autotest_frame_pkg.sv
design/autotest_ctrl_pkg.sv
design/block_reader.sv
design/uut_runner.sv
design/result_checker.sv
design/test_sequencer.sv
design/autotest_top.sv
testbench/autotest_asserts.sv
testbench/autotest_tb.sv

// ==== testbench/autotest_golden.txt ====
// signature operand_1 operand_2 operand_3 expected latency mismatch, all hex
// latency 0 means the uut never ends; the last block carries a bad signature
AABBCCDD 00000001 00000002 00000000 00000003 5  0
AABBCCDD 12345678 11111111 00000000 23456789 1  0
AABBCCDD 0000000F 00000001 000000FF 000000EF C  0
AABBCCDD FFFFFFFF 00000001 A5A5A5A5 A5A5A5A5 3  0
AABBCCDD 00000100 00000200 00000300 00000001 7  1
AABBCCDD 80000000 80000000 0000FFFF 0000FFFF 0  0
AABBCCDD 01020304 10203040 00000000 11223345 2  1
AABBCCDD DEADBEEF 00000000 FFFFFFFF 21524110 14 0
AABBCCDD 7FFFFFFF 00000001 0F0F0F0F 8F0F0F0F 9  0
DDCCBBAA 00000000 00000000 00000000 00000000 0  0
